// ==== hw/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32
`define RESET_PC   32'h0000_0000
// addi x0, x0, 0
`define NOP_INSN   32'h0000_0013

`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_STORE  7'b0100011

`define F3_ADD 3'b000
`define F3_SLT 3'b010
`define F3_XOR 3'b100
`define F3_OR  3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_SW  3'b010

`define F7_SUB 7'b0100000

`define ALU_OP_W   3
`define ALU_ADD    3'd0
`define ALU_SUB    3'd1
`define ALU_AND    3'd2
`define ALU_OR     3'd3
`define ALU_XOR    3'd4
`define ALU_SLT    3'd5
`define ALU_PASS_B 3'd6

`define FWD_W   2
`define FWD_REG 2'd0
`define FWD_MEM 2'd1
`define FWD_WB  2'd2

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none

`include "core_defines.svh"

package core_pkg;

  // one instruction word seen through the base encodings
  typedef union packed {
    struct packed {
      logic [6:0]             funct7;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } r_view;
    struct packed {
      logic [11:0]            imm;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`REG_ADDR_W-1:0] rd;
      logic [6:0]             opcode;
    } i_view;
    // b-type shares this layout, bits scrambled differently
    struct packed {
      logic [6:0]             imm_hi;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [4:0]             imm_lo;
      logic [6:0]             opcode;
    } s_view;
  } insn_u;

endpackage

`default_nettype wire

// ==== hw/pipe_ifs.sv ====
`default_nettype none

`include "core_defines.svh"

interface fetch_if;
  logic             valid;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] insn;

  modport source (output valid, pc, insn);
  modport sink   (input valid, pc, insn);
endinterface

interface decode_if;
  logic                   valid;
  logic [`XLEN-1:0]       pc;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       imm;
  logic [`ALU_OP_W-1:0]   alu_op;
  logic                   use_imm;
  logic                   is_branch;
  logic                   branch_ne;
  logic                   is_jal;
  logic                   is_store;
  logic                   writes_rd;

  modport source (output valid, pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm,
                  alu_op, use_imm, is_branch, branch_ne, is_jal, is_store, writes_rd);
  modport sink   (input valid, pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm,
                  alu_op, use_imm, is_branch, branch_ne, is_jal, is_store, writes_rd);
  modport hazard (input rs1_addr, rs2_addr);
endinterface

interface exec_if;
  logic                   valid;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic                   writes_rd;
  logic [`XLEN-1:0]       result;
  logic                   is_store;
  logic [`XLEN-1:0]       store_data;

  modport source (output valid, rd_addr, writes_rd, result, is_store, store_data);
  modport sink   (input valid, rd_addr, writes_rd, result, is_store, store_data);
  modport fwd    (input valid, rd_addr, writes_rd, result);
endinterface

interface wb_if;
  logic                   valid;
  logic                   we;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic [`XLEN-1:0]       wdata;

  modport source (output valid, we, rd_addr, wdata);
  modport sink   (input valid, we, rd_addr, wdata);
  modport fwd    (input valid, we, rd_addr, wdata);
endinterface

interface ctl_if;
  logic              stall;
  logic              flush_if_id;
  logic              flush_id_ex;
  logic [`FWD_W-1:0] fwd_a_sel;
  logic [`FWD_W-1:0] fwd_b_sel;

  modport source (output stall, flush_if_id, flush_id_ex, fwd_a_sel, fwd_b_sel);
  modport stage  (input stall, flush_if_id, flush_id_ex, fwd_a_sel, fwd_b_sel);
endinterface

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`default_nettype none

`include "core_defines.svh"

module fetch_stage (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             redirect_i,
  input  wire logic [`XLEN-1:0] target_i,
  output logic      [`XLEN-1:0] imem_addr_o,
  input  wire logic [`XLEN-1:0] imem_rdata_i,
  ctl_if.stage                  ctl,
  fetch_if.source               fetch
);

  logic [`XLEN-1:0] pc_q;

  assign imem_addr_o = pc_q;

  // redirect waits with everything else while stalled
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= `RESET_PC;
    end else if (!ctl.stall) begin
      pc_q <= redirect_i ? target_i : pc_q + 'd4;
    end
  end

  ////////////////////////////////////////
  // if/id register

  always_ff @(posedge clk_i) begin
    if (rst_i || ctl.flush_if_id) begin
      fetch.valid <= 1'b0;
      fetch.insn  <= `NOP_INSN;
    end else if (!ctl.stall) begin
      fetch.valid <= 1'b1;
      fetch.insn  <= imem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!ctl.stall) begin
      fetch.pc <= pc_q;
    end
  end

  // branch and jump offsets from decode keep the pc on word boundaries
  pc_aligned_a: assert property (@(posedge clk_i) disable iff (rst_i) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

`include "core_defines.svh"

module decode_stage
  import core_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_i,
  fetch_if.sink     fetch,
  wb_if.sink        wb,
  ctl_if.stage      ctl,
  decode_if.source  dec
);

  insn_u                insn;
  logic [`XLEN-1:0]     imm;
  logic [`ALU_OP_W-1:0] alu_op;
  logic                 use_imm;
  logic                 is_branch;
  logic                 branch_ne;
  logic                 is_jal;
  logic                 is_store;
  logic                 writes_rd;
  logic                 rf_we;
  logic [`XLEN-1:0]     regs [`NUM_REGS];
  logic [`XLEN-1:0]     rs1_data;
  logic [`XLEN-1:0]     rs2_data;

  function automatic logic [`ALU_OP_W-1:0] alu_from_f3(input logic [2:0] f3, input logic sub);
    case (f3)
      `F3_ADD: return sub ? `ALU_SUB : `ALU_ADD;
      `F3_SLT: return `ALU_SLT;
      `F3_XOR: return `ALU_XOR;
      `F3_OR:  return `ALU_OR;
      `F3_AND: return `ALU_AND;
      default: return `ALU_ADD;
    endcase
  endfunction

  assign insn = fetch.insn;

  always_comb begin
    imm       = {{20{insn.i_view.imm[11]}}, insn.i_view.imm};
    alu_op    = `ALU_ADD;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    branch_ne = insn.r_view.funct3 == `F3_BNE;
    is_jal    = 1'b0;
    is_store  = 1'b0;
    writes_rd = 1'b0;
    case (insn.r_view.opcode)
      `OPC_OP: begin
        alu_op    = alu_from_f3(insn.r_view.funct3, insn.r_view.funct7 == `F7_SUB);
        writes_rd = 1'b1;
      end
      `OPC_OP_IMM: begin
        alu_op    = alu_from_f3(insn.i_view.funct3, 1'b0);
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      `OPC_LUI: begin
        imm       = {insn.i_view.imm, insn.i_view.rs1, insn.i_view.funct3, 12'b0};
        alu_op    = `ALU_PASS_B;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      `OPC_BRANCH: begin
        imm = {{19{insn.s_view.imm_hi[6]}}, insn.s_view.imm_hi[6], insn.s_view.imm_lo[0],
               insn.s_view.imm_hi[5:0], insn.s_view.imm_lo[4:1], 1'b0};
        is_branch = (insn.s_view.funct3 == `F3_BEQ) || (insn.s_view.funct3 == `F3_BNE);
      end
      `OPC_JAL: begin
        imm = {{12{insn.i_view.imm[11]}}, insn.i_view.rs1, insn.i_view.funct3,
               insn.i_view.imm[0], insn.i_view.imm[10:1], 1'b0};
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      `OPC_STORE: begin
        imm      = {{20{insn.s_view.imm_hi[6]}}, insn.s_view.imm_hi, insn.s_view.imm_lo};
        use_imm  = 1'b1;
        is_store = insn.s_view.funct3 == `F3_SW;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // register file, write-first

  assign rf_we = wb.valid && wb.we && (wb.rd_addr != '0);

  always_ff @(posedge clk_i) begin
    if (rf_we) begin
      regs[wb.rd_addr] <= wb.wdata;
    end
  end

  always_comb begin
    rs1_data = regs[insn.r_view.rs1];
    rs2_data = regs[insn.r_view.rs2];
    if (rf_we && wb.rd_addr == insn.r_view.rs1) rs1_data = wb.wdata;
    if (rf_we && wb.rd_addr == insn.r_view.rs2) rs2_data = wb.wdata;
    if (insn.r_view.rs1 == '0) rs1_data = '0;
    if (insn.r_view.rs2 == '0) rs2_data = '0;
  end

  ////////////////////////////////////////
  // id/ex register

  always_ff @(posedge clk_i) begin
    if (rst_i || ctl.flush_id_ex) begin
      dec.valid     <= 1'b0;
      dec.is_branch <= 1'b0;
      dec.is_jal    <= 1'b0;
      dec.is_store  <= 1'b0;
      dec.writes_rd <= 1'b0;
    end else if (!ctl.stall) begin
      dec.valid     <= fetch.valid;
      dec.is_branch <= is_branch;
      dec.is_jal    <= is_jal;
      dec.is_store  <= is_store;
      dec.writes_rd <= writes_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!ctl.stall) begin
      dec.pc        <= fetch.pc;
      dec.rs1_addr  <= insn.r_view.rs1;
      dec.rs2_addr  <= insn.r_view.rs2;
      dec.rd_addr   <= insn.r_view.rd;
      dec.rs1_data  <= rs1_data;
      dec.rs2_data  <= rs2_data;
      dec.imm       <= imm;
      dec.alu_op    <= alu_op;
      dec.use_imm   <= use_imm;
      dec.branch_ne <= branch_ne;
    end
  end

  // x0 must reach execute as zero, so no later result may be forwarded over it
  x0_zero_a: assert property (@(posedge clk_i) disable iff (rst_i)
    dec.valid |-> (dec.rs1_addr != '0 || ctl.fwd_a_sel == `FWD_REG) &&
                  (dec.rs2_addr != '0 || ctl.fwd_b_sel == `FWD_REG));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

`include "core_defines.svh"

module execute_stage (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  decode_if.sink           dec,
  ctl_if.stage             ctl,
  wb_if.fwd                wb,
  exec_if.source           exe,
  output logic             redirect_o,
  output logic [`XLEN-1:0] target_o
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] fwd_b;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] result;
  logic             taken;

  function automatic logic [`XLEN-1:0] fwd_mux(input logic [`FWD_W-1:0] sel,
                                               input logic [`XLEN-1:0] reg_val,
                                               input logic [`XLEN-1:0] mem_val,
                                               input logic [`XLEN-1:0] wb_val);
    case (sel)
      `FWD_MEM: return mem_val;
      `FWD_WB:  return wb_val;
      default:  return reg_val;
    endcase
  endfunction

  // mem result comes straight off our own ex/mem register
  assign op_a  = fwd_mux(ctl.fwd_a_sel, dec.rs1_data, exe.result, wb.wdata);
  assign fwd_b = fwd_mux(ctl.fwd_b_sel, dec.rs2_data, exe.result, wb.wdata);
  assign op_b  = dec.use_imm ? dec.imm : fwd_b;

  always_comb begin
    case (dec.alu_op)
      `ALU_SUB:    alu_out = op_a - op_b;
      `ALU_AND:    alu_out = op_a & op_b;
      `ALU_OR:     alu_out = op_a | op_b;
      `ALU_XOR:    alu_out = op_a ^ op_b;
      `ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      `ALU_PASS_B: alu_out = op_b;
      default:     alu_out = op_a + op_b;
    endcase
  end

  // jal links pc+4
  assign result = dec.is_jal ? dec.pc + 'd4 : alu_out;

  assign taken      = dec.is_branch && ((op_a == fwd_b) != dec.branch_ne);
  assign redirect_o = dec.valid && (dec.is_jal || taken);
  assign target_o   = dec.pc + dec.imm;

  ////////////////////////////////////////
  // ex/mem register

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exe.valid     <= 1'b0;
      exe.writes_rd <= 1'b0;
      exe.is_store  <= 1'b0;
    end else if (!ctl.stall) begin
      exe.valid     <= dec.valid;
      exe.writes_rd <= dec.writes_rd;
      exe.is_store  <= dec.is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!ctl.stall) begin
      exe.rd_addr    <= dec.rd_addr;
      exe.result     <= result;
      exe.store_data <= fwd_b;
    end
  end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`default_nettype none

`include "core_defines.svh"

module memory_stage (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  exec_if.sink             exe,
  ctl_if.stage             ctl,
  output logic             mem_valid_o,
  output logic [`XLEN-1:0] mem_addr_o,
  output logic [`XLEN-1:0] mem_wdata_o,
  input  wire logic        mem_done_i,
  output logic             mem_busy_o,
  wb_if.source             wb
);

  // ex/mem holds under stall, so the request stays put until done
  assign mem_valid_o = exe.valid && exe.is_store;
  assign mem_addr_o  = exe.result;
  assign mem_wdata_o = exe.store_data;
  assign mem_busy_o  = mem_valid_o && !mem_done_i;

  ////////////////////////////////////////
  // mem/wb register

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb.valid <= 1'b0;
      wb.we    <= 1'b0;
    end else if (!ctl.stall) begin
      wb.valid <= exe.valid;
      wb.we    <= exe.writes_rd && !exe.is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!ctl.stall) begin
      wb.rd_addr <= exe.rd_addr;
      wb.wdata   <= exe.result;
    end
  end

  // request must not move while the responder is still working on it
  store_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_busy_o |=> mem_valid_o && $stable(mem_addr_o) && $stable(mem_wdata_o));

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`default_nettype none

`include "core_defines.svh"

module hazard_unit (
  decode_if.hazard  dec,
  exec_if.fwd       exe,
  wb_if.fwd         wb,
  input  wire logic redirect_i,
  input  wire logic mem_busy_i,
  ctl_if.source     ctl
);

  logic mem_wr;
  logic wb_wr;

  // mem is younger than wb so it wins
  function automatic logic [`FWD_W-1:0] pick(input logic [`REG_ADDR_W-1:0] src,
                                             input logic mem_hit,
                                             input logic [`REG_ADDR_W-1:0] mem_rd,
                                             input logic wb_hit,
                                             input logic [`REG_ADDR_W-1:0] wb_rd);
    if (src == '0) return `FWD_REG;
    if (mem_hit && mem_rd == src) return `FWD_MEM;
    if (wb_hit && wb_rd == src) return `FWD_WB;
    return `FWD_REG;
  endfunction

  assign mem_wr = exe.valid && exe.writes_rd;
  assign wb_wr  = wb.valid && wb.we;

  assign ctl.fwd_a_sel = pick(dec.rs1_addr, mem_wr, exe.rd_addr, wb_wr, wb.rd_addr);
  assign ctl.fwd_b_sel = pick(dec.rs2_addr, mem_wr, exe.rd_addr, wb_wr, wb.rd_addr);

  // whole pipe freezes while a store waits, redirect is held for later
  assign ctl.stall       = mem_busy_i;
  assign ctl.flush_if_id = redirect_i && !mem_busy_i;
  assign ctl.flush_id_ex = redirect_i && !mem_busy_i;

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
`default_nettype none

`include "core_defines.svh"

module core_top (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  output logic      [`XLEN-1:0] imem_addr_o,
  input  wire logic [`XLEN-1:0] imem_rdata_i,
  output logic                  mem_valid_o,
  output logic      [`XLEN-1:0] mem_addr_o,
  output logic      [`XLEN-1:0] mem_wdata_o,
  input  wire logic             mem_done_i
);

  logic             redirect;
  logic [`XLEN-1:0] target;
  logic             mem_busy;

  fetch_if  fetch_bus ();
  decode_if dec_bus ();
  exec_if   exe_bus ();
  wb_if     wb_bus ();
  ctl_if    ctl_bus ();

  ////////////////////////////////////////
  // stages

  fetch_stage i_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .redirect_i   (redirect),
    .target_i     (target),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata_i),
    .ctl          (ctl_bus),
    .fetch        (fetch_bus)
  );

  decode_stage i_decode (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .fetch (fetch_bus),
    .wb    (wb_bus),
    .ctl   (ctl_bus),
    .dec   (dec_bus)
  );

  execute_stage i_execute (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dec        (dec_bus),
    .ctl        (ctl_bus),
    .wb         (wb_bus),
    .exe        (exe_bus),
    .redirect_o (redirect),
    .target_o   (target)
  );

  memory_stage i_memory (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .exe         (exe_bus),
    .ctl         (ctl_bus),
    .mem_valid_o (mem_valid_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_done_i  (mem_done_i),
    .mem_busy_o  (mem_busy),
    .wb          (wb_bus)
  );

  hazard_unit i_hazard (
    .dec        (dec_bus),
    .exe        (exe_bus),
    .wb         (wb_bus),
    .redirect_i (redirect),
    .mem_busy_i (mem_busy),
    .ctl        (ctl_bus)
  );

endmodule

`default_nettype wire

// ==== tb/core_tb.sv ====
`default_nettype none

`include "core_defines.svh"

module core_tb
  import core_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_rdata;
  logic             mem_valid;
  logic [`XLEN-1:0] mem_addr;
  logic [`XLEN-1:0] mem_wdata;
  logic             mem_done;

  logic [`XLEN-1:0] rom [256];
  logic [`XLEN-1:0] exp_addr [$];
  logic [`XLEN-1:0] exp_data [$];
  int               prog_len;
  int               n_exp;
  int               seen;
  int               errors;
  int               extra_stores;
  int               stall_cycles;
  int               test_err [4];
  integer           seed;

  core_top i_dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .mem_valid_o  (mem_valid),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_done_i   (mem_done)
  );

  assign imem_rdata = rom[imem_addr[9:2]];

  ////////////////////////////////////////
  // instruction encoders

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                        input int rd);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], `F3_SW, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_lui(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], `OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_jal(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
  endfunction

  task automatic append_insn(input logic [31:0] word);
    rom[prog_len[7:0]] = word;
    prog_len = prog_len + 1;
  endtask

  task automatic load_program();
    int i;
    // unused words hold addi x0, x0, index
    for (i = 0; i < 256; i++) begin
      rom[i[7:0]] = enc_i(i, 0, `F3_ADD, 0);
    end
    // alu ops, stores at 0x100
    append_insn(enc_i(23, 0, `F3_ADD, 1));
    append_insn(enc_i(-7, 0, `F3_ADD, 2));
    append_insn(enc_i(256, 0, `F3_ADD, 10));
    append_insn(enc_r(7'd0, 2, 1, `F3_ADD, 3));
    append_insn(enc_s(0, 3, 10));
    append_insn(enc_r(`F7_SUB, 2, 1, `F3_ADD, 3));
    append_insn(enc_s(4, 3, 10));
    append_insn(enc_r(7'd0, 2, 1, `F3_AND, 3));
    append_insn(enc_s(8, 3, 10));
    append_insn(enc_r(7'd0, 2, 1, `F3_OR, 3));
    append_insn(enc_s(12, 3, 10));
    append_insn(enc_r(7'd0, 2, 1, `F3_XOR, 3));
    append_insn(enc_s(16, 3, 10));
    append_insn(enc_r(7'd0, 1, 2, `F3_SLT, 3));
    append_insn(enc_s(20, 3, 10));
    append_insn(enc_r(7'd0, 2, 1, `F3_SLT, 3));
    append_insn(enc_s(24, 3, 10));
    append_insn(enc_i(240, 2, `F3_AND, 3));
    append_insn(enc_s(28, 3, 10));
    append_insn(enc_i(-256, 1, `F3_OR, 3));
    append_insn(enc_s(32, 3, 10));
    append_insn(enc_i(1365, 2, `F3_XOR, 3));
    append_insn(enc_s(36, 3, 10));
    append_insn(enc_i(-5, 2, `F3_SLT, 3));
    append_insn(enc_s(40, 3, 10));
    append_insn(enc_lui(32'hABCDE, 3));
    append_insn(enc_s(44, 3, 10));
    // dependency distances 1 to 3, stores at 0x200
    append_insn(enc_i(512, 0, `F3_ADD, 11));
    append_insn(enc_i(5, 0, `F3_ADD, 12));
    append_insn(enc_i(3, 12, `F3_ADD, 13));
    append_insn(enc_i(100, 12, `F3_ADD, 14));
    append_insn(enc_r(`F7_SUB, 12, 13, `F3_ADD, 15));
    append_insn(enc_s(0, 13, 11));
    append_insn(enc_s(4, 14, 11));
    append_insn(enc_s(8, 15, 11));
    append_insn(enc_i(77, 0, `F3_ADD, 0));
    append_insn(enc_r(7'd0, 0, 0, `F3_ADD, 16));
    append_insn(enc_s(12, 16, 11));
    append_insn(enc_s(16, 0, 11));
    // branches and jal, stores at 0x300
    append_insn(enc_i(768, 0, `F3_ADD, 17));
    append_insn(enc_i(9, 0, `F3_ADD, 18));
    append_insn(enc_i(9, 0, `F3_ADD, 19));
    append_insn(enc_b(12, 19, 18, `F3_BEQ));
    append_insn(enc_s(0, 18, 17));
    append_insn(enc_s(4, 18, 17));
    append_insn(enc_b(12, 19, 18, `F3_BNE));
    append_insn(enc_s(8, 19, 17));
    append_insn(enc_b(8, 0, 18, `F3_BEQ));
    append_insn(enc_s(12, 0, 17));
    append_insn(enc_b(12, 0, 18, `F3_BNE));
    append_insn(enc_s(16, 18, 17));
    append_insn(enc_s(20, 18, 17));
    append_insn(enc_jal(12, 20));
    append_insn(enc_s(24, 18, 17));
    append_insn(enc_s(28, 18, 17));
    append_insn(enc_s(32, 20, 17));
    append_insn(enc_jal(0, 0));
  endtask

  ////////////////////////////////////////
  // isa reference model

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      `F3_ADD: return sub ? a - b : a + b;
      `F3_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `F3_XOR: return a ^ b;
      `F3_OR:  return a | b;
      `F3_AND: return a & b;
      default: return 32'd0;
    endcase
  endfunction

  // runs until the jal-to-self and queues every store in order
  function automatic int run_model();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ir;
    insn_u       w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        halted;
    int          k;
    for (k = 0; k < 32; k++) begin
      x[k[4:0]] = 32'd0;
    end
    pc = `RESET_PC;
    halted = 1'b0;
    k = 0;
    while (!halted && k < 1000) begin
      ir = rom[pc[9:2]];
      w = ir;
      a = x[w.r_view.rs1];
      b = x[w.r_view.rs2];
      imm_i = {{20{ir[31]}}, ir[31:20]};
      imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      next_pc = pc + 32'd4;
      case (w.r_view.opcode)
        `OPC_OP: x[w.r_view.rd] = alu_ref(w.r_view.funct3, w.r_view.funct7 == `F7_SUB, a, b);
        `OPC_OP_IMM: x[w.i_view.rd] = alu_ref(w.i_view.funct3, 1'b0, a, imm_i);
        `OPC_LUI: x[w.r_view.rd] = {ir[31:12], 12'd0};
        `OPC_STORE: begin
          exp_addr.push_back(a + imm_s);
          exp_data.push_back(b);
        end
        `OPC_BRANCH: begin
          if ((a == b) != (w.s_view.funct3 == `F3_BNE)) begin
            next_pc = pc + imm_b;
          end
        end
        `OPC_JAL: begin
          halted = imm_j == 32'd0;
          x[w.r_view.rd] = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        default: ;
      endcase
      x[5'd0] = 32'd0;
      pc = next_pc;
      k++;
    end
    return exp_addr.size();
  endfunction

  function automatic string test_name(input logic [1:0] tid);
    case (tid)
      2'd1: return "alu_ops";
      2'd2: return "dependencies";
      2'd3: return "control_flow";
      default: return "reset";
    endcase
  endfunction

  ////////////////////////////////////////
  // clock, data port responder, compare

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    int wait_cnt;
    seed = 71919;
    wait_cnt = -1;
    mem_done = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      // done was high last cycle, so that store completed
      if (mem_done) wait_cnt = -1;
      mem_done = 1'b0;
      if (!rst && mem_valid) begin
        if (wait_cnt < 0) wait_cnt = $unsigned($random(seed)) % 4;
        if (wait_cnt == 0) begin
          mem_done = 1'b1;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

  initial begin
    logic [1:0] tid;
    forever begin
      @(negedge clk);
      if (!rst && mem_valid && !mem_done) stall_cycles++;
      if (!rst && mem_valid && mem_done) begin
        if (seen >= n_exp) begin
          $display("t=%0t: store to %h with data %h came after the last expected one",
                   $time, mem_addr, mem_wdata);
          errors++;
          extra_stores++;
        end else begin
          tid = exp_addr[seen][9:8];
          if (mem_addr != exp_addr[seen]) begin
            $display("[FAIL] t=%0t mem_addr_o got %h expected %h",
                     $time, mem_addr, exp_addr[seen]);
            errors++;
            test_err[tid]++;
          end
          if (mem_wdata != exp_data[seen]) begin
            $display("[FAIL] t=%0t mem_wdata_o got %h expected %h",
                     $time, mem_wdata, exp_data[seen]);
            errors++;
            test_err[tid]++;
          end
          seen++;
          if (seen == n_exp || exp_addr[seen][9:8] != tid) begin
            $display("test %s finished, %0d errors", test_name(tid), test_err[tid]);
          end
        end
      end
    end
  end

  // stores that never arrive end the run here
  initial begin
    @(negedge rst);
    repeat (prog_len * 40) @(posedge clk);
    $display("timeout after %0d cycles, %0d of %0d expected stores never arrived",
             prog_len * 40, n_exp - seen, n_exp);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence

  initial begin
    rst = 1'b1;
    prog_len = 0;
    seen = 0;
    errors = 0;
    extra_stores = 0;
    stall_cycles = 0;
    test_err = '{default: 0};
    load_program();
    n_exp = run_model();
    repeat (4) begin
      @(posedge clk);
      #2;
      if (mem_valid !== 1'b0) begin
        $display("[FAIL] t=%0t mem_valid_o got %b expected %b", $time, mem_valid, 1'b0);
        errors++;
        test_err[0]++;
      end
    end
    rst = 1'b0;
    @(negedge clk);
    if (imem_addr !== `RESET_PC) begin
      $display("[FAIL] t=%0t imem_addr_o got %h expected %h", $time, imem_addr, `RESET_PC);
      errors++;
      test_err[0]++;
    end
    $display("test reset finished, %0d errors", test_err[0]);
    wait (seen == n_exp);
    // extra stores would show up in this window
    repeat (20) @(posedge clk);
    if (stall_cycles == 0) begin
      $display("the data port never held a store waiting for done");
      errors++;
    end
    $display("test back_pressure finished, %0d of %0d stores in order, %0d extra, %0d stalls",
             seen, n_exp, extra_stores, stall_cycles);
    $display("stores %0d of %0d, errors %0d", seen, n_exp, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/core_pkg.sv
hw/pipe_ifs.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/hazard_unit.sv
hw/core_top.sv
tb/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module core_tb \
  --Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/core_tb_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -Fqx -- '** PASS **' <<< "$sim_out"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
